// File: invaders_pkg.sv
// Shared types, screen geometry and timing constants for the invaders game core
// Referenced by scoped name from every RTL module
package invaders_pkg;

  // Coordinate and colour types
  typedef logic [7:0] xcoord_t;
  typedef logic [6:0] ycoord_t;
  typedef logic [2:0] colour_t;
  typedef logic [2:0] obj_idx_t;  // 0 player, 1..3 aliens, 4 bullet

  // Frame loop states of the sequencer
  typedef enum logic [3:0] {
    s_idle,
    s_start,
    s_draw,
    s_draw_wait,
    s_wait_tick,
    s_erase,
    s_erase_wait,
    s_update,
    s_check,
    s_done
  } seq_state_t;

  // Screen size in pixels
  localparam int screen_w = 160;
  localparam int screen_h = 120;

  localparam int num_aliens  = 3;
  localparam int num_objects = num_aliens + 2;

  // Player sits near the bottom edge
  localparam xcoord_t player_start_x = 8'd68;
  localparam ycoord_t player_y       = ycoord_t'(screen_h - 9);

  // Alien lanes, each alien sweeps between its left border and left + lane width
  localparam ycoord_t alien_start_y              = 7'd15;
  localparam xcoord_t alien_left [num_aliens]    = '{8'd50, 8'd70, 8'd90};
  localparam xcoord_t alien_lane_w               = 8'd19;

  localparam ycoord_t bullet_start_y = player_y - 7'd1;  // One row above the player

  // RGB, one bit per channel
  localparam colour_t col_black  = 3'b000;
  localparam colour_t col_player = 3'b010;
  localparam colour_t col_alien  = 3'b100;
  localparam colour_t col_bullet = 3'b111;

  // Clock cycles per move tick, short so simulation stays quick
  localparam int frame_div = 64;
  typedef logic [$clog2(frame_div)-1:0] frame_cnt_t;

endpackage

// File: button_sync.sv
// Brings the three game buttons into the clock domain
// A fire press is held as pending until the motion logic launches the bullet
module button_sync (
  input  logic clk,
  input  logic rst,
  input  logic btn_left,
  input  logic btn_right,
  input  logic btn_fire,
  input  logic fire_taken,
  output logic move_left,
  output logic move_right,
  output logic fire_pending
);

  // Bit 0 left, bit 1 right, bit 2 fire
  logic [2:0] sync_1;
  logic [2:0] sync_2;
  logic       fire_d;  // Previous synchronized fire level
  logic       fire_rise;

  assign fire_rise = sync_2[2] && !fire_d;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_1 <= '0;
      sync_2 <= '0;
      fire_d <= 1'b0;
    end else begin
      sync_1 <= {btn_fire, btn_right, btn_left};
      sync_2 <= sync_1;
      fire_d <= sync_2[2];
    end
  end

  // A new press wins over a take in the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fire_pending <= 1'b0;
    end else if (fire_rise) begin
      fire_pending <= 1'b1;
    end else if (fire_taken) begin
      fire_pending <= 1'b0;
    end
  end

  assign move_left  = sync_2[0];
  assign move_right = sync_2[1];

endmodule

// File: frame_timer.sv
// Divides the clock into move ticks while a game runs
// The tick stays pending until the sequencer takes it, later ticks merge into it
module frame_timer (
  input  logic clk,
  input  logic rst,
  input  logic in_game,
  input  logic tick_take,
  output logic tick_pending
);

  invaders_pkg::frame_cnt_t cnt;
  logic                     wrap;

  assign wrap = (cnt == invaders_pkg::frame_cnt_t'(invaders_pkg::frame_div - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt          <= '0;
      tick_pending <= 1'b0;
    end else if (!in_game) begin
      cnt          <= '0;  // Restart phase for the next game
      tick_pending <= 1'b0;
    end else begin
      cnt <= wrap ? '0 : cnt + 1'b1;
      if (wrap) begin
        tick_pending <= 1'b1;
      end else if (tick_take) begin
        tick_pending <= 1'b0;
      end
    end
  end

endmodule

// File: game_sequencer.sv
// Frame loop FSM: draw all objects, wait for a tick, erase, move, check hits
// Also owns the alien alive flags and the win/lose status
module game_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  logic                  tick_pending,
  input  logic                  plot_done,
  input  logic                  bullet_flying,
  input  invaders_pkg::xcoord_t player_x,
  input  invaders_pkg::xcoord_t alien_x [invaders_pkg::num_aliens],
  input  invaders_pkg::xcoord_t bullet_x,
  input  invaders_pkg::ycoord_t alien_y [invaders_pkg::num_aliens],
  input  invaders_pkg::ycoord_t bullet_y,
  output logic                  tick_take,
  output logic                  update_en,
  output logic                  restart,
  output logic                  bullet_stop,
  output logic                  plot_start,
  output invaders_pkg::xcoord_t plot_x,
  output invaders_pkg::ycoord_t plot_y,
  output invaders_pkg::colour_t plot_colour,
  output logic                  in_game,
  output logic                  won,
  output logic                  lost
);

  invaders_pkg::seq_state_t state;
  invaders_pkg::obj_idx_t   obj_idx;
  invaders_pkg::colour_t    draw_colour;

  logic [invaders_pkg::num_aliens-1:0] alive;
  logic [invaders_pkg::num_aliens-1:0] hit_vec;
  logic [invaders_pkg::num_aliens-1:0] alive_next;
  logic                                reached;
  logic                                last_obj;

  assign last_obj = (obj_idx == invaders_pkg::obj_idx_t'(invaders_pkg::num_objects - 1));

  // Bullet against live aliens, lowest index wins
  always_comb begin
    hit_vec = '0;
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      if (hit_vec == '0 && bullet_flying && alive[i] &&
          bullet_x == alien_x[i] && bullet_y == alien_y[i]) begin
        hit_vec[i] = 1'b1;
      end
    end
  end

  assign alive_next = alive & ~hit_vec;

  // Any survivor down on the player's row
  always_comb begin
    reached = 1'b0;
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      if (alive_next[i] && alien_y[i] >= invaders_pkg::player_y) begin
        reached = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= invaders_pkg::s_idle;
      obj_idx <= '0;
      alive   <= '0;
      won     <= 1'b0;
      lost    <= 1'b0;
    end else begin
      case (state)
        invaders_pkg::s_idle, invaders_pkg::s_done: begin
          if (go) begin
            won   <= 1'b0;
            lost  <= 1'b0;
            state <= invaders_pkg::s_start;
          end
        end
        invaders_pkg::s_start: begin
          alive   <= '1;
          obj_idx <= '0;
          state   <= invaders_pkg::s_draw;
        end
        invaders_pkg::s_draw: state <= invaders_pkg::s_draw_wait;
        invaders_pkg::s_draw_wait: begin
          if (plot_done) begin
            obj_idx <= last_obj ? '0 : obj_idx + 1'b1;
            state   <= last_obj ? invaders_pkg::s_wait_tick : invaders_pkg::s_draw;
          end
        end
        invaders_pkg::s_wait_tick: begin
          if (tick_pending) state <= invaders_pkg::s_erase;
        end
        invaders_pkg::s_erase: state <= invaders_pkg::s_erase_wait;
        invaders_pkg::s_erase_wait: begin
          if (plot_done) begin
            obj_idx <= last_obj ? '0 : obj_idx + 1'b1;
            state   <= last_obj ? invaders_pkg::s_update : invaders_pkg::s_erase;
          end
        end
        invaders_pkg::s_update: state <= invaders_pkg::s_check;  // Positions settle here
        invaders_pkg::s_check: begin
          alive <= alive_next;
          if (alive_next == '0) begin
            won   <= 1'b1;
            state <= invaders_pkg::s_done;
          end else if (reached) begin
            lost  <= 1'b1;
            state <= invaders_pkg::s_done;
          end else begin
            state <= invaders_pkg::s_draw;
          end
        end
        default: state <= invaders_pkg::s_idle;
      endcase
    end
  end

  // Position and draw colour of the current object
  always_comb begin
    plot_x      = bullet_x;
    plot_y      = bullet_y;
    draw_colour = bullet_flying ? invaders_pkg::col_bullet : invaders_pkg::col_black;
    if (obj_idx == '0) begin
      plot_x      = player_x;
      plot_y      = invaders_pkg::player_y;
      draw_colour = invaders_pkg::col_player;
    end
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      if (obj_idx == invaders_pkg::obj_idx_t'(i + 1)) begin
        plot_x      = alien_x[i];
        plot_y      = alien_y[i];
        draw_colour = alive[i] ? invaders_pkg::col_alien : invaders_pkg::col_black;
      end
    end
  end

  assign plot_colour = (state == invaders_pkg::s_erase) ? invaders_pkg::col_black : draw_colour;

  assign plot_start  = (state == invaders_pkg::s_draw) || (state == invaders_pkg::s_erase);
  assign tick_take   = (state == invaders_pkg::s_wait_tick) && tick_pending;
  assign update_en   = (state == invaders_pkg::s_update);
  assign restart     = (state == invaders_pkg::s_start);
  assign bullet_stop = (state == invaders_pkg::s_check) && (hit_vec != '0);
  assign in_game     = (state != invaders_pkg::s_idle) && (state != invaders_pkg::s_done);

endmodule

// File: object_motion.sv
// Position registers for player, aliens and bullet
// One movement step per update_en pulse and start positions reloaded on restart
module object_motion (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  restart,
  input  logic                  update_en,
  input  logic                  bullet_stop,
  input  logic                  move_left,
  input  logic                  move_right,
  input  logic                  fire_pending,
  output logic                  fire_taken,
  output invaders_pkg::xcoord_t player_x,
  output invaders_pkg::xcoord_t alien_x [invaders_pkg::num_aliens],
  output invaders_pkg::ycoord_t alien_y [invaders_pkg::num_aliens],
  output invaders_pkg::xcoord_t bullet_x,
  output invaders_pkg::ycoord_t bullet_y,
  output logic                  bullet_flying
);

  logic go_left, go_right;

  // Exactly one direction held, and not already at the edge
  assign go_left  = move_left && !move_right && (player_x != '0);
  assign go_right = move_right && !move_left &&
                    (player_x != invaders_pkg::xcoord_t'(invaders_pkg::screen_w - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      player_x <= invaders_pkg::player_start_x;
    end else if (restart) begin
      player_x <= invaders_pkg::player_start_x;
    end else if (update_en) begin
      if (go_left) player_x <= player_x - 1'b1;
      else if (go_right) player_x <= player_x + 1'b1;
    end
  end

  for (genvar i = 0; i < invaders_pkg::num_aliens; i++) begin : g_alien
    localparam invaders_pkg::xcoord_t right_edge =
      invaders_pkg::alien_left[i] + invaders_pkg::alien_lane_w;

    invaders_pkg::xcoord_t lane_x;
    invaders_pkg::ycoord_t lane_y;
    logic                  dir_right;

    always_ff @(posedge clk or posedge rst) begin
      if (rst || restart) begin
        lane_x    <= invaders_pkg::alien_left[i];
        lane_y    <= invaders_pkg::alien_start_y;
        dir_right <= 1'b1;
      end else if (update_en) begin
        if (dir_right && lane_x == right_edge) begin
          dir_right <= 1'b0;  // Turn back and drop a row
          lane_y    <= lane_y + 1'b1;
        end else if (!dir_right && lane_x == invaders_pkg::alien_left[i]) begin
          dir_right <= 1'b1;
          lane_y    <= lane_y + 1'b1;
        end else begin
          lane_x <= dir_right ? lane_x + 1'b1 : lane_x - 1'b1;
        end
      end
    end

    assign alien_x[i] = lane_x;
    assign alien_y[i] = lane_y;
  end

  // Launch only from an idle bullet
  assign fire_taken = update_en && !bullet_flying && fire_pending;

  always_ff @(posedge clk or posedge rst) begin
    if (rst || restart) begin
      bullet_x      <= invaders_pkg::player_start_x;
      bullet_y      <= invaders_pkg::bullet_start_y;
      bullet_flying <= 1'b0;
    end else if (bullet_stop) begin
      bullet_y      <= invaders_pkg::bullet_start_y;  // Parks at the column it hit
      bullet_flying <= 1'b0;
    end else if (update_en) begin
      if (bullet_flying) begin
        if (bullet_y == '0) begin
          bullet_y      <= invaders_pkg::bullet_start_y;
          bullet_flying <= 1'b0;
        end else begin
          bullet_y <= bullet_y - 1'b1;
        end
      end else if (fire_pending) begin
        bullet_x      <= player_x;
        bullet_y      <= invaders_pkg::bullet_start_y;
        bullet_flying <= 1'b1;
      end
    end
  end

endmodule

// File: pixel_writer.sv
// Turns one plot command into a four-phase req/ack write to the frame buffer
// plot_done pulses once ack has returned low
module pixel_writer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  plot_start,
  input  invaders_pkg::xcoord_t plot_x,
  input  invaders_pkg::ycoord_t plot_y,
  input  invaders_pkg::colour_t plot_colour,
  input  logic                  fb_ack,
  output invaders_pkg::xcoord_t pix_x,
  output invaders_pkg::ycoord_t pix_y,
  output invaders_pkg::colour_t pix_colour,
  output logic                  pix_req,
  output logic                  plot_done
);

  typedef enum logic [1:0] {
    w_idle,
    w_request,
    w_release
  } wr_state_t;

  wr_state_t state;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= w_idle;
      pix_req   <= 1'b0;
      plot_done <= 1'b0;
    end else begin
      plot_done <= 1'b0;
      case (state)
        w_idle: begin
          if (plot_start) begin
            pix_req <= 1'b1;
            state   <= w_request;
          end
        end
        w_request: begin
          if (fb_ack) begin
            pix_req <= 1'b0;
            state   <= w_release;
          end
        end
        w_release: begin
          if (!fb_ack) begin
            plot_done <= 1'b1;  // Handshake fully closed
            state     <= w_idle;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

  // Pixel data held stable for the whole handshake
  always_ff @(posedge clk) begin
    if (state == w_idle && plot_start) begin
      pix_x      <= plot_x;
      pix_y      <= plot_y;
      pix_colour <= plot_colour;
    end
  end

endmodule

// File: invaders_top.sv
// Top level of the invaders game core
// Buttons in, single-pixel req/ack writes out toward an external frame buffer
module invaders_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  logic                  btn_left,
  input  logic                  btn_right,
  input  logic                  btn_fire,
  input  logic                  fb_ack,
  output invaders_pkg::xcoord_t pix_x,
  output invaders_pkg::ycoord_t pix_y,
  output invaders_pkg::colour_t pix_colour,
  output logic                  pix_req,
  output logic                  in_game,
  output logic                  won,
  output logic                  lost
);

  logic move_left, move_right, fire_pending, fire_taken;
  logic tick_pending, tick_take;
  logic update_en, restart, bullet_stop, bullet_flying;
  logic plot_start, plot_done;

  invaders_pkg::xcoord_t player_x, bullet_x, plot_x;
  invaders_pkg::xcoord_t alien_x [invaders_pkg::num_aliens];
  invaders_pkg::ycoord_t alien_y [invaders_pkg::num_aliens];
  invaders_pkg::ycoord_t bullet_y, plot_y;
  invaders_pkg::colour_t plot_colour;

  // Input side
  button_sync i_button_sync (
    .clk          (clk),
    .rst          (rst),
    .btn_left     (btn_left),
    .btn_right    (btn_right),
    .btn_fire     (btn_fire),
    .fire_taken   (fire_taken),
    .move_left    (move_left),
    .move_right   (move_right),
    .fire_pending (fire_pending)
  );

  frame_timer i_frame_timer (
    .clk          (clk),
    .rst          (rst),
    .in_game      (in_game),
    .tick_take    (tick_take),
    .tick_pending (tick_pending)
  );

  game_sequencer i_game_sequencer (
    .clk           (clk),
    .rst           (rst),
    .go            (go),
    .tick_pending  (tick_pending),
    .plot_done     (plot_done),
    .bullet_flying (bullet_flying),
    .player_x      (player_x),
    .alien_x       (alien_x),
    .bullet_x      (bullet_x),
    .alien_y       (alien_y),
    .bullet_y      (bullet_y),
    .tick_take     (tick_take),
    .update_en     (update_en),
    .restart       (restart),
    .bullet_stop   (bullet_stop),
    .plot_start    (plot_start),
    .plot_x        (plot_x),
    .plot_y        (plot_y),
    .plot_colour   (plot_colour),
    .in_game       (in_game),
    .won           (won),
    .lost          (lost)
  );

  object_motion i_object_motion (
    .clk           (clk),
    .rst           (rst),
    .restart       (restart),
    .update_en     (update_en),
    .bullet_stop   (bullet_stop),
    .move_left     (move_left),
    .move_right    (move_right),
    .fire_pending  (fire_pending),
    .fire_taken    (fire_taken),
    .player_x      (player_x),
    .alien_x       (alien_x),
    .alien_y       (alien_y),
    .bullet_x      (bullet_x),
    .bullet_y      (bullet_y),
    .bullet_flying (bullet_flying)
  );

  // Output side
  pixel_writer i_pixel_writer (
    .clk         (clk),
    .rst         (rst),
    .plot_start  (plot_start),
    .plot_x      (plot_x),
    .plot_y      (plot_y),
    .plot_colour (plot_colour),
    .fb_ack      (fb_ack),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_colour  (pix_colour),
    .pix_req     (pix_req),
    .plot_done   (plot_done)
  );

endmodule

// File: tb_clock_gen.sv
// Free-running clock for the invaders testbench
// Period is twice half_period, starts low at time zero
module tb_clock_gen #(
  parameter int half_period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

// File: tb_invaders.sv
// Testbench for invaders_top with a req/ack frame-buffer model
// Every frame's ten pixel writes are compared with a software model of the game rules
module tb_invaders;

  localparam int write_timeout = 500;  // In cycles and long enough for a tick wait
  localparam int end_timeout   = 200;
  localparam int end_quiet     = 20;   // Cycles watched for stray writes after a game

  typedef struct packed {
    invaders_pkg::xcoord_t                                px;
    invaders_pkg::xcoord_t [invaders_pkg::num_aliens-1:0] ax;
    invaders_pkg::ycoord_t [invaders_pkg::num_aliens-1:0] ay;
    logic [invaders_pkg::num_aliens-1:0]                  dir_r;
    logic [invaders_pkg::num_aliens-1:0]                  alive;
    invaders_pkg::xcoord_t                                bx;
    invaders_pkg::ycoord_t                                by;
    logic                                                 flying;
    logic                                                 fire_pend;
    logic                                                 won;
    logic                                                 lost;
  } model_t;

  logic clk, rst, go, btn_left, btn_right, btn_fire, fb_ack;
  logic pix_req, in_game, won, lost;
  invaders_pkg::xcoord_t pix_x;
  invaders_pkg::ycoord_t pix_y;
  invaders_pkg::colour_t pix_colour;

  // Completed writes in order
  invaders_pkg::xcoord_t wr_x [$];
  invaders_pkg::ycoord_t wr_y [$];
  invaders_pkg::colour_t wr_c [$];

  model_t ref_state;
  logic   prev_fire = 1'b0;
  logic   aborted   = 1'b0;
  int     frame_no  = 0;
  int     n_checks  = 0;
  int     n_mismatch = 0;
  int     n_other   = 0;

  tb_clock_gen #(.half_period(4)) i_clock_gen (.clk(clk));

  invaders_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .btn_left   (btn_left),
    .btn_right  (btn_right),
    .btn_fire   (btn_fire),
    .fb_ack     (fb_ack),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_colour (pix_colour),
    .pix_req    (pix_req),
    .in_game    (in_game),
    .won        (won),
    .lost       (lost)
  );

  // Frame buffer model acks after 0 to 5 cycles and releases after req drops
  initial begin
    int                    wait_left;
    invaders_pkg::xcoord_t cap_x;
    invaders_pkg::ycoord_t cap_y;
    invaders_pkg::colour_t cap_c;
    void'($urandom(32'h96ce4b63));  // Seeds the random ack delays
    fb_ack    = 1'b0;
    wait_left = 0;
    forever begin
      @(posedge clk);
      #1;
      if (pix_req && !fb_ack) begin
        if (wait_left == 0) begin
          fb_ack = 1'b1;
          cap_x  = pix_x;
          cap_y  = pix_y;
          cap_c  = pix_colour;
        end else begin
          wait_left--;
        end
      end else if (fb_ack && !pix_req) begin
        fb_ack = 1'b0;  // Write complete once ack is low again
        wr_x.push_back(cap_x);
        wr_y.push_back(cap_y);
        wr_c.push_back(cap_c);
        wait_left = $urandom_range(5, 0);
      end
    end
  end

  task automatic check_coord_x(input string what, input invaders_pkg::xcoord_t got,
                               input invaders_pkg::xcoord_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_coord_y(input string what, input invaders_pkg::ycoord_t got,
                               input invaders_pkg::ycoord_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_colour(input string what, input invaders_pkg::colour_t got,
                              input invaders_pkg::colour_t exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", what, got, exp);
    end
  endtask

  function automatic model_t start_model();
    model_t s;
    s = '0;
    s.px = invaders_pkg::player_start_x;
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      s.ax[i]    = invaders_pkg::alien_left[i];
      s.ay[i]    = invaders_pkg::alien_start_y;
      s.dir_r[i] = 1'b1;
      s.alive[i] = 1'b1;
    end
    s.bx = invaders_pkg::player_start_x;
    s.by = invaders_pkg::bullet_start_y;
    return s;
  endfunction

  // One movement step plus the hit and end-of-game rules
  function automatic model_t step_model(input model_t s, input logic left, input logic right);
    model_t                n;
    invaders_pkg::xcoord_t edge_r;
    int                    hit;
    n = s;
    if (left && !right && s.px != '0) begin
      n.px = s.px - 1'b1;
    end else if (right && !left &&
                 s.px != invaders_pkg::xcoord_t'(invaders_pkg::screen_w - 1)) begin
      n.px = s.px + 1'b1;
    end
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      edge_r = invaders_pkg::alien_left[i] + invaders_pkg::alien_lane_w;
      if (s.dir_r[i] && s.ax[i] == edge_r) begin
        n.dir_r[i] = 1'b0;
        n.ay[i]    = s.ay[i] + 1'b1;
      end else if (!s.dir_r[i] && s.ax[i] == invaders_pkg::alien_left[i]) begin
        n.dir_r[i] = 1'b1;
        n.ay[i]    = s.ay[i] + 1'b1;
      end else begin
        n.ax[i] = s.dir_r[i] ? s.ax[i] + 1'b1 : s.ax[i] - 1'b1;
      end
    end
    if (s.flying) begin
      if (s.by == '0) begin
        n.by     = invaders_pkg::bullet_start_y;
        n.flying = 1'b0;
      end else begin
        n.by = s.by - 1'b1;
      end
    end else if (s.fire_pend) begin
      n.bx        = s.px;  // Column before this step's player move
      n.by        = invaders_pkg::bullet_start_y;
      n.flying    = 1'b1;
      n.fire_pend = 1'b0;
    end
    hit = -1;
    for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
      if (hit < 0 && n.flying && n.alive[i] && n.bx == n.ax[i] && n.by == n.ay[i]) begin
        hit = i;
      end
    end
    if (hit >= 0) begin
      n.alive[hit] = 1'b0;
      n.by         = invaders_pkg::bullet_start_y;
      n.flying     = 1'b0;
    end
    if (n.alive == '0) begin
      n.won = 1'b1;
    end else begin
      for (int i = 0; i < invaders_pkg::num_aliens; i++) begin
        if (n.alive[i] && n.ay[i] >= invaders_pkg::player_y) n.lost = 1'b1;
      end
    end
    return n;
  endfunction

  // Would a shot fired now hit alien k with no further buttons
  function automatic logic launch_hits_alien(input model_t s, input int k);
    model_t t;
    t = s;
    t.fire_pend = 1'b1;
    t = step_model(t, 1'b0, 1'b0);
    for (int n = 0; n < 130; n++) begin
      if (!t.alive[k]) return 1'b1;
      if (!t.flying || t.won || t.lost) return 1'b0;
      t = step_model(t, 1'b0, 1'b0);
    end
    return 1'b0;
  endfunction

  task automatic expected_plot(input model_t s, input int obj, output invaders_pkg::xcoord_t x,
                               output invaders_pkg::ycoord_t y, output invaders_pkg::colour_t c);
    if (obj == 0) begin
      x = s.px;
      y = invaders_pkg::player_y;
      c = invaders_pkg::col_player;
    end else if (obj <= invaders_pkg::num_aliens) begin
      x = s.ax[obj-1];
      y = s.ay[obj-1];
      c = s.alive[obj-1] ? invaders_pkg::col_alien : invaders_pkg::col_black;
    end else begin
      x = s.bx;
      y = s.by;
      c = s.flying ? invaders_pkg::col_bullet : invaders_pkg::col_black;
    end
  endtask

  task automatic next_write(output invaders_pkg::xcoord_t x, output invaders_pkg::ycoord_t y,
                            output invaders_pkg::colour_t c, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (wr_x.size() == 0 && n < write_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (wr_x.size() != 0) begin
      x  = wr_x.pop_front();
      y  = wr_y.pop_front();
      c  = wr_c.pop_front();
      ok = 1'b1;
    end else begin
      n_other++;
      $display("Timeout: no pixel write arrived in frame %0d", frame_no);
    end
  endtask

  task automatic wait_game_end();
    int n;
    n = 0;
    while (in_game && n < end_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (in_game) begin
      n_other++;
      aborted = 1'b1;
      $display("Timeout: the game did not stop after frame %0d", frame_no);
    end else begin
      check_flag("won", won, ref_state.won);
      check_flag("lost", lost, ref_state.lost);
      // Stopped FSM must stay silent toward the frame buffer
      for (int i = 0; i < end_quiet; i++) begin
        @(posedge clk);
        #1;
        check_flag("pix_req", pix_req, 1'b0);
      end
      if (wr_x.size() != 0) begin
        n_other++;
        $display("Pixel writes arrived after the game had ended");
      end
    end
  endtask

  // Five draws, new buttons, five erases, then the model steps
  task automatic run_frame(input logic left, input logic right, input logic fire);
    invaders_pkg::xcoord_t got_x, exp_x;
    invaders_pkg::ycoord_t got_y, exp_y;
    invaders_pkg::colour_t got_c, exp_c;
    logic                  ok;
    string                 tag;
    for (int pass = 0; pass < 2; pass++) begin
      for (int obj = 0; obj < invaders_pkg::num_objects; obj++) begin
        if (!aborted) begin
          next_write(got_x, got_y, got_c, ok);
          if (!ok) begin
            aborted = 1'b1;
          end else begin
            expected_plot(ref_state, obj, exp_x, exp_y, exp_c);
            if (pass == 1) exp_c = invaders_pkg::col_black;
            tag = $sformatf("frame %0d pass %0d object %0d", frame_no, pass, obj);
            check_coord_x({"pix_x, ", tag}, got_x, exp_x);
            check_coord_y({"pix_y, ", tag}, got_y, exp_y);
            check_colour({"pix_colour, ", tag}, got_c, exp_c);
          end
        end
      end
      if (pass == 0 && !aborted) begin
        check_flag("in_game", in_game, 1'b1);
        btn_left  = left;  // Held through this frame's update
        btn_right = right;
        btn_fire  = fire;
        if (fire && !prev_fire) ref_state.fire_pend = 1'b1;
        prev_fire = fire;
      end
    end
    if (!aborted) begin
      ref_state = step_model(ref_state, left, right);
      frame_no++;
      if (ref_state.won || ref_state.lost) wait_game_end();
    end
  endtask

  task automatic run_frames(input int count, input logic left, input logic right,
                            input logic fire);
    for (int i = 0; i < count; i++) begin
      if (!aborted && !ref_state.won && !ref_state.lost) run_frame(left, right, fire);
    end
  endtask

  task automatic start_game();
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    prev_fire = 1'b0;
    go        = 1'b1;
    @(posedge clk);
    #1;
    go        = 1'b0;
    ref_state = start_model();
  endtask

  // Walk under each alien in turn and fire when the shot will land
  task automatic hunt_aliens();
    invaders_pkg::xcoord_t target;
    logic                  left, right, fire;
    int                    n;
    for (int k = 0; k < invaders_pkg::num_aliens; k++) begin
      target = invaders_pkg::alien_left[k] + 8'd9;  // Mid lane
      n      = 0;
      while (ref_state.alive[k] && !aborted && !ref_state.lost && n < 300) begin
        left  = 1'b0;
        right = 1'b0;
        fire  = 1'b0;
        if (!ref_state.flying && !ref_state.fire_pend) begin
          if (ref_state.px < target) right = 1'b1;
          else if (ref_state.px > target) left = 1'b1;
          else if (launch_hits_alien(ref_state, k)) fire = 1'b1;
        end
        run_frame(left, right, fire);
        n++;
      end
      if (ref_state.alive[k] && !aborted) begin
        n_other++;
        $display("Alien %0d was not hit within 300 frames", k);
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    go        = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_fire  = 1'b0;
    ref_state = start_model();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet before go
    for (int i = 0; i < 50; i++) begin
      @(posedge clk);
      #1;
      check_flag("pix_req", pix_req, 1'b0);
      check_flag("in_game", in_game, 1'b0);
      check_flag("won", won, 1'b0);
      check_flag("lost", lost, 1'b0);
    end

    start_game();
    run_frames(45, 1'b0, 1'b0, 1'b0);   // Sweep and first descents
    run_frames(95, 1'b0, 1'b1, 1'b0);   // Reach and clamp at the right edge
    run_frames(80, 1'b1, 1'b0, 1'b0);   // Halfway back to the left
    run_frames(5, 1'b1, 1'b1, 1'b0);    // Both held mid-screen, no move
    run_frames(85, 1'b1, 1'b0, 1'b0);   // On to the left edge and clamp
    run_frames(1, 1'b0, 1'b0, 1'b1);    // Shot from column 0 misses every lane
    run_frames(115, 1'b0, 1'b0, 1'b0);
    if (!aborted) hunt_aliens();
    if (!aborted && !ref_state.won) begin
      n_other++;
      $display("The game was not won after all aliens were targeted");
    end

    if (!aborted) begin
      start_game();
      run_frames(2100, 1'b0, 1'b0, 1'b0);
      if (!aborted && !ref_state.lost) begin
        n_other++;
        $display("The aliens did not reach the player row");
      end
    end

    $display("Summary: %0d compares, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: flist.f
invaders_pkg.sv
button_sync.sv
frame_timer.sv
game_sequencer.sv
object_motion.sv
pixel_writer.sv
invaders_top.sv
tb_clock_gen.sv
tb_invaders.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_invaders -f flist.f -o sim_invaders \
  > build.log 2>&1 &&
  ./obj_dir/sim_invaders > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "Simulation PASS" ||
  { echo "Simulation FAIL, see build.log and sim.log"; exit 1; }
